//--- rtl/scPkg.sv
package scPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  // Configuration word width
  localparam int WordWidth = 16;
  // Words held in the queue
  localparam int FifoDepth = 8;
  // Word count field, must hold FifoDepth
  localparam int CountWidth = 4;
  // Serial reset low time in Clk5M cycles
  localparam int ResetCycles = 4;
  // Clk5M cycles per serial bit
  localparam int BitCycles = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Command and result records
  ////////////////////////////////////////////////////////////////////////////

  // Encodings 4 to 7 are illegal
  typedef enum logic [2:0] {
    CmdNop   = 3'd0,
    CmdPush  = 3'd1,
    CmdClear = 3'd2,
    CmdShift = 3'd3
  } cmdOpT;

  typedef struct packed {
    cmdOpT                 op;
    logic [WordWidth-1:0]  data;
  } cmdT;

  typedef enum logic [1:0] {
    StatOk      = 2'd0,
    StatEmpty   = 2'd1,
    StatIllegal = 2'd2
  } statusT;

  typedef struct packed {
    statusT                status;
    logic [CountWidth-1:0] wordCount;
    logic [WordWidth-1:0]  checksum;
  } resultT;

  // Serializer FSM
  typedef enum logic [2:0] {
    ShIdle, ShReset, ShRead, ShLatency, ShLoad, ShBits, ShGap
  } shiftStateT;

endpackage

//--- rtl/scCmdDecode.sv
module scCmdDecode (
  input  logic                        Clk5M,
  input  logic                        reset_n,
  input  logic                        cmdValid,
  input  scPkg::cmdT                  cmd,
  input  logic                        fifoFull,
  input  logic                        shiftBusy,
  input  logic                        resBusy,
  output logic                        cmdReady,
  output logic                        pushEn,
  output logic [scPkg::WordWidth-1:0] pushWord,
  output logic                        clearEn,
  output logic                        shiftStart,
  output logic                        illegalEn
);

  logic pushBlock;
  logic accept;

  // Push in flight not yet counted by the FIFO
  assign pushBlock = fifoFull || pushEn;

  always_comb begin
    // Hold off while a shift or a result is pending
    cmdReady = !shiftBusy && !resBusy && !shiftStart;
    // Pushes also wait for room
    if (cmd.op == scPkg::CmdPush && pushBlock) begin
      cmdReady = 1'b0;
    end
  end

  assign accept = cmdValid && cmdReady;

  // One-cycle control pulses per accepted command
  always_ff @(posedge Clk5M or negedge reset_n) begin
    if (!reset_n) begin
      pushEn     <= 1'b0;
      clearEn    <= 1'b0;
      shiftStart <= 1'b0;
      illegalEn  <= 1'b0;
    end else begin
      pushEn     <= 1'b0;
      clearEn    <= 1'b0;
      shiftStart <= 1'b0;
      illegalEn  <= 1'b0;
      if (accept) begin
        case (cmd.op)
          scPkg::CmdNop: begin
            // Taken and dropped
          end
          scPkg::CmdPush:  pushEn     <= 1'b1;
          scPkg::CmdClear: clearEn    <= 1'b1;
          scPkg::CmdShift: shiftStart <= 1'b1;
          default:         illegalEn  <= 1'b1;
        endcase
      end
    end
  end

  // Word travels alongside pushEn
  always_ff @(posedge Clk5M) begin
    if (accept) begin
      pushWord <= cmd.data;
    end
  end

endmodule

//--- rtl/scWordFifo.sv
module scWordFifo (
  input  logic                        Clk5M,
  input  logic                        reset_n,
  input  logic                        pushEn,
  input  logic [scPkg::WordWidth-1:0] pushWord,
  input  logic                        readEn,
  input  logic                        clearEn,
  output logic [scPkg::WordWidth-1:0] fifoData,
  output logic                        fifoEmpty,
  output logic                        fifoFull
);

  logic [scPkg::WordWidth-1:0]           mem [scPkg::FifoDepth];
  logic [$clog2(scPkg::FifoDepth)-1:0]   wrPtr;
  logic [$clog2(scPkg::FifoDepth)-1:0]   rdPtr;
  // One extra bit so a full queue is distinct from empty
  logic [$clog2(scPkg::FifoDepth+1)-1:0] count;
  logic doPush;
  logic doPop;

  assign fifoEmpty = (count == 0);
  assign fifoFull  = (count == scPkg::FifoDepth);

  // Overflow and underflow requests are dropped
  assign doPush = pushEn && !fifoFull;
  assign doPop  = readEn && !fifoEmpty;

  // Storage and registered read port
  always_ff @(posedge Clk5M) begin
    if (doPush) begin
      mem[wrPtr] <= pushWord;
    end
    if (doPop) begin
      fifoData <= mem[rdPtr];
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge Clk5M or negedge reset_n) begin
    if (!reset_n) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else if (clearEn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- rtl/bitShiftOut.sv
module bitShiftOut (
  input  logic                        Clk5M,
  input  logic                        reset_n,
  input  logic                        shiftStart,
  input  logic                        fifoEmpty,
  input  logic [scPkg::WordWidth-1:0] fifoData,
  output logic                        readEn,
  output logic                        wordLoaded,
  output logic [scPkg::WordWidth-1:0] loadedWord,
  output logic                        shiftDone,
  output logic                        shiftBusy,
  // Chip pins
  output logic                        SerialClock,
  output logic                        SerialReset,
  output logic                        SerialData
);

  scPkg::shiftStateT                     state;
  // Shared by the reset pulse and the bit phases
  logic [$clog2(scPkg::BitCycles)-1:0]   delayCnt;
  logic [$clog2(scPkg::WordWidth)-1:0]   bitCnt;
  logic [scPkg::WordWidth-1:0]           shiftReg;
  logic                                  bitsEn;

  assign shiftBusy = (state != scPkg::ShIdle);
  assign bitsEn    = (state == scPkg::ShBits);

  ////////////////////////////////////////////////////////////////////////////
  // Pin drive
  ////////////////////////////////////////////////////////////////////////////

  // Low for the first half of a bit, high for the second
  assign SerialClock = bitsEn & delayCnt[$left(delayCnt)];
  // MSB first, parked low outside the bits
  assign SerialData  = bitsEn & shiftReg[scPkg::WordWidth-1];

  ////////////////////////////////////////////////////////////////////////////
  // Shift FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk5M or negedge reset_n) begin
    if (!reset_n) begin
      state       <= scPkg::ShIdle;
      delayCnt    <= '0;
      bitCnt      <= '0;
      readEn      <= 1'b0;
      wordLoaded  <= 1'b0;
      shiftDone   <= 1'b0;
      SerialReset <= 1'b1;
    end else begin
      wordLoaded <= 1'b0;
      shiftDone  <= 1'b0;
      case (state)
        scPkg::ShIdle: begin
          if (shiftStart) begin
            // Chip reset goes low right away
            SerialReset <= 1'b0;
            delayCnt    <= '0;
            state       <= scPkg::ShReset;
          end
        end
        scPkg::ShReset: begin
          if (delayCnt == scPkg::ResetCycles - 1) begin
            SerialReset <= 1'b1;
            delayCnt    <= '0;
            state       <= scPkg::ShRead;
          end else begin
            delayCnt <= delayCnt + 1'b1;
          end
        end
        scPkg::ShRead: begin
          if (!fifoEmpty) begin
            readEn <= 1'b1;
            state  <= scPkg::ShLatency;
          end else begin
            // Queue drained, shift is over
            shiftDone <= 1'b1;
            state     <= scPkg::ShIdle;
          end
        end
        scPkg::ShLatency: begin
          // FIFO data lands at the end of this cycle
          readEn <= 1'b0;
          state  <= scPkg::ShLoad;
        end
        scPkg::ShLoad: begin
          wordLoaded <= 1'b1;
          delayCnt   <= '0;
          bitCnt     <= '0;
          state      <= scPkg::ShBits;
        end
        scPkg::ShBits: begin
          if (delayCnt == scPkg::BitCycles - 1) begin
            delayCnt <= '0;
            if (bitCnt == scPkg::WordWidth - 1) begin
              state <= scPkg::ShGap;
            end else begin
              bitCnt <= bitCnt + 1'b1;
            end
          end else begin
            delayCnt <= delayCnt + 1'b1;
          end
        end
        // Clock gated off, last bit ends cleanly
        scPkg::ShGap: state <= scPkg::ShRead;
        default: state <= scPkg::ShIdle;
      endcase
    end
  end

  // Shift register and the copy handed to the result block
  always_ff @(posedge Clk5M) begin
    if (state == scPkg::ShLoad) begin
      shiftReg   <= fifoData;
      loadedWord <= fifoData;
    end else if (bitsEn && delayCnt == scPkg::BitCycles - 1) begin
      shiftReg <= shiftReg << 1;
    end
  end

endmodule

//--- rtl/scResult.sv
module scResult (
  input  logic                        Clk5M,
  input  logic                        reset_n,
  input  logic                        wordLoaded,
  input  logic [scPkg::WordWidth-1:0] loadedWord,
  input  logic                        shiftDone,
  input  logic                        illegalEn,
  input  logic                        clearEn,
  input  logic                        resReady,
  output logic                        resValid,
  output scPkg::resultT               res,
  output logic                        resBusy
);

  logic [scPkg::CountWidth-1:0] wordCnt;
  logic [scPkg::WordWidth-1:0]  xorAcc;

  // Covers the cycle before resValid rises
  assign resBusy = resValid | shiftDone | illegalEn;

  // Accumulators and valid flag
  always_ff @(posedge Clk5M or negedge reset_n) begin
    if (!reset_n) begin
      resValid <= 1'b0;
      wordCnt  <= '0;
      xorAcc   <= '0;
    end else begin
      if (shiftDone || illegalEn) begin
        resValid <= 1'b1;
      end else if (resValid && resReady) begin
        // Record taken, start fresh
        resValid <= 1'b0;
        wordCnt  <= '0;
        xorAcc   <= '0;
      end
      if (clearEn) begin
        wordCnt <= '0;
        xorAcc  <= '0;
      end else if (wordLoaded) begin
        wordCnt <= wordCnt + 1'b1;
        xorAcc  <= xorAcc ^ loadedWord;
      end
    end
  end

  // Record held stable while resValid waits
  always_ff @(posedge Clk5M) begin
    if (shiftDone) begin
      res.status    <= (wordCnt == 0) ? scPkg::StatEmpty : scPkg::StatOk;
      res.wordCount <= wordCnt;
      res.checksum  <= xorAcc;
    end else if (illegalEn) begin
      res.status    <= scPkg::StatIllegal;
      res.wordCount <= '0;
      res.checksum  <= '0;
    end
  end

endmodule

//--- rtl/slowControlTop.sv
module slowControlTop (
  input  logic          Clk5M,
  input  logic          reset_n,
  // Command channel
  input  logic          cmdValid,
  output logic          cmdReady,
  input  scPkg::cmdT    cmd,
  // Result channel
  output logic          resValid,
  input  logic          resReady,
  output scPkg::resultT res,
  // Chip pins
  output logic          SerialClock,
  output logic          SerialReset,
  output logic          SerialData
);

  logic                        pushEn;
  logic [scPkg::WordWidth-1:0] pushWord;
  logic                        clearEn;
  logic                        shiftStart;
  logic                        illegalEn;
  logic                        readEn;
  logic                        fifoEmpty;
  logic                        fifoFull;
  logic [scPkg::WordWidth-1:0] fifoData;
  logic                        wordLoaded;
  logic [scPkg::WordWidth-1:0] loadedWord;
  logic                        shiftDone;
  logic                        shiftBusy;
  logic                        resBusy;

  // Command front end
  scCmdDecode uDecode (
    .Clk5M, .reset_n, .cmdValid, .cmd, .fifoFull, .shiftBusy, .resBusy,
    .cmdReady, .pushEn, .pushWord, .clearEn, .shiftStart, .illegalEn
  );

  // Word queue
  scWordFifo uFifo (
    .Clk5M, .reset_n, .pushEn, .pushWord, .readEn, .clearEn,
    .fifoData, .fifoEmpty, .fifoFull
  );

  // Serializer driving the chip
  bitShiftOut uShift (
    .Clk5M, .reset_n, .shiftStart, .fifoEmpty, .fifoData,
    .readEn, .wordLoaded, .loadedWord, .shiftDone, .shiftBusy,
    .SerialClock, .SerialReset, .SerialData
  );

  // Result record
  scResult uResult (
    .Clk5M, .reset_n, .wordLoaded, .loadedWord, .shiftDone, .illegalEn,
    .clearEn, .resReady, .resValid, .res, .resBusy
  );

endmodule

//--- dv/slowControlTb.sv
module slowControlTb;
  timeunit 1ns;
  timeprecision 1ps;

  // Longest shift is 8 words of about 70 cycles each
  localparam int TimeoutCycles = 2000;

  logic          Clk5M;
  logic          reset_n;
  logic          cmdValid;
  logic          cmdReady;
  scPkg::cmdT    cmd;
  logic          resValid;
  logic          resReady;
  scPkg::resultT res;
  logic          SerialClock;
  logic          SerialReset;
  logic          SerialData;

  // Serial monitor totals compared as deltas per test
  logic [15:0] rxWords[$];
  logic [15:0] rxShift = '0;
  int          rxBits = 0;
  int          clkEdgeTotal = 0;
  int          lowResetEdges = 0;
  int          resetPulseTotal = 0;
  int          resetLowTotal = 0;
  int          edgesAtRise = 0;

  // Reference queue of pushed words
  logic [15:0] refQ[$];
  logic [31:0] lcgState;
  int          tests;
  int          failedTests;
  logic        hung;
  logic        testBad;

  slowControlTop u_dut (
    .Clk5M, .reset_n, .cmdValid, .cmdReady, .cmd, .resValid, .resReady, .res,
    .SerialClock, .SerialReset, .SerialData
  );

  initial begin
    Clk5M = 1'b0;
    forever #100 Clk5M = ~Clk5M;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
    $display("mismatch %s got %0h expected %0h", name, got, exp);
    testBad = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Serial pin monitor
  ////////////////////////////////////////////////////////////////////////////

  // Chip samples MSB first on the rising serial clock
  always @(posedge SerialClock) begin
    clkEdgeTotal++;
    if (!SerialReset) lowResetEdges++;
    rxShift = {rxShift[14:0], SerialData};
    rxBits++;
    if (rxBits == 16) begin
      rxWords.push_back(rxShift);
      rxBits = 0;
    end
  end

  always @(posedge SerialReset) begin
    resetPulseTotal++;
    edgesAtRise = clkEdgeTotal;
  end

  always @(posedge Clk5M) begin
    if (reset_n && !SerialReset) resetLowTotal++;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Handshake waits
  ////////////////////////////////////////////////////////////////////////////

  // Returns on the edge where the command transfers
  task automatic waitCmdReady();
    int n;
    for (n = 0; n < TimeoutCycles; n++) begin
      @(posedge Clk5M);
      if (cmdReady) break;
    end
    if (n == TimeoutCycles) begin
      $display("timeout while waiting for the command to be accepted");
      hung = 1'b1;
    end
  endtask

  task automatic waitResValid();
    int n;
    for (n = 0; n < TimeoutCycles; n++) begin
      @(posedge Clk5M);
      if (resValid) break;
    end
    if (n == TimeoutCycles) begin
      $display("timeout while waiting for a result record");
      hung = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    int            fd;
    string         line;
    int            op;
    int            data;
    int            blk;
    int            expStat;
    int            expCnt;
    int            expSum;
    int            clkBase;
    int            pulseBase;
    int            lowBase;
    int            lowEdgeBase;
    int            rxBase;
    int            stall;
    logic [15:0]   expWords[$];
    scPkg::resultT held;
    reset_n     = 1'b0;
    cmdValid    = 1'b0;
    cmd         = '0;
    resReady    = 1'b0;
    lcgState    = 32'hb1f2_c41f;
    tests       = 0;
    failedTests = 0;
    hung        = 1'b0;
    testBad     = 1'b0;
    repeat (2) @(posedge Clk5M);
    #10 reset_n = 1'b1;
    fd = $fopen("dv/sc_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the tests file dv/sc_tests.txt");
      hung = 1'b1;
    end
    while (!hung && !$feof(fd)) begin
      if ($fgets(line, fd) == 0) break;
      // Comment and blank lines do not scan
      if ($sscanf(line, "%h %h %d %d %d %h", op, data, blk, expStat, expCnt, expSum) != 6)
        continue;
      tests++;
      testBad = 1'b0;
      // Random idle gap before the command
      @(posedge Clk5M);
      repeat (int'(nextRand() % 3)) @(posedge Clk5M);
      clkBase     = clkEdgeTotal;
      pulseBase   = resetPulseTotal;
      lowBase     = resetLowTotal;
      lowEdgeBase = lowResetEdges;
      rxBase      = rxWords.size();
      #10;
      cmd      = {op[2:0], data[15:0]};
      cmdValid = 1'b1;
      if (blk != 0) begin
        // Full FIFO must refuse the push
        repeat (6) begin
          @(posedge Clk5M);
          if (cmdReady) begin
            $display("push was offered ready while the FIFO was full");
            testBad = 1'b1;
          end
        end
        #10 cmdValid = 1'b0;
      end else begin
        waitCmdReady();
        #10 cmdValid = 1'b0;
        case (op)
          1: refQ.push_back(data[15:0]);
          2: refQ.delete();
          3: begin
            expWords = refQ;
            refQ.delete();
          end
          default: ;
        endcase
      end
      // Shift and illegal opcodes return a result
      if (!hung && blk == 0 && op >= 3) begin
        waitResValid();
        if (!hung) begin
          held  = res;
          // At least one stalled cycle per record
          stall = 1 + int'(nextRand() % 5);
          repeat (stall) begin
            @(posedge Clk5M);
            if (!resValid) begin
              $display("result valid dropped before the record was taken");
              testBad = 1'b1;
            end
            if (res !== held) reportMismatch("res", 32'(res), 32'(held));
            if (cmdReady) begin
              $display("command ready was high while a result was pending");
              testBad = 1'b1;
            end
          end
          #10 resReady = 1'b1;
          @(posedge Clk5M);
          // Record as seen on the transfer edge
          if (!resValid) begin
            $display("result valid dropped before the record was taken");
            testBad = 1'b1;
          end
          if (res !== held) reportMismatch("res", 32'(res), 32'(held));
          #10 resReady = 1'b0;
          if (32'(held.status) != expStat)
            reportMismatch("status", 32'(held.status), expStat);
          if (32'(held.wordCount) != expCnt)
            reportMismatch("wordCount", 32'(held.wordCount), expCnt);
          if (32'(held.checksum) != expSum)
            reportMismatch("checksum", 32'(held.checksum), expSum);
        end
      end
      if (op == 3 && blk == 0) begin
        if (rxWords.size() - rxBase != expWords.size())
          reportMismatch("serial words", rxWords.size() - rxBase, expWords.size());
        for (int i = 0; i < expWords.size() && i < rxWords.size() - rxBase; i++) begin
          if (rxWords[rxBase + i] !== expWords[i])
            reportMismatch("SerialData word", 32'(rxWords[rxBase + i]), 32'(expWords[i]));
        end
        if (clkEdgeTotal - clkBase != 16 * expWords.size())
          reportMismatch("SerialClock edges", clkEdgeTotal - clkBase, 16 * expWords.size());
        if (resetPulseTotal - pulseBase != 1)
          reportMismatch("SerialReset pulses", resetPulseTotal - pulseBase, 1);
        if (resetLowTotal - lowBase != scPkg::ResetCycles)
          reportMismatch("SerialReset low cycles", resetLowTotal - lowBase, scPkg::ResetCycles);
        if (edgesAtRise != clkBase) begin
          $display("serial clock rose before the chip reset pulse ended");
          testBad = 1'b1;
        end
        if (lowResetEdges != lowEdgeBase) begin
          $display("serial clock rose while the chip reset was low");
          testBad = 1'b1;
        end
      end else begin
        // No pin activity outside a shift
        if (clkEdgeTotal != clkBase)
          reportMismatch("SerialClock edges", clkEdgeTotal - clkBase, 0);
        if (resetPulseTotal != pulseBase)
          reportMismatch("SerialReset pulses", resetPulseTotal - pulseBase, 0);
        if (resetLowTotal != lowBase)
          reportMismatch("SerialReset low cycles", resetLowTotal - lowBase, 0);
      end
      if (testBad || hung) failedTests++;
      $display("test %0d op %0h %s", tests, op, (testBad || hung) ? "failed" : "passed");
    end
    if (fd != 0) $fclose(fd);
    $display("tests %0d passed %0d failed %0d", tests, tests - failedTests, failedTests);
    if (failedTests == 0 && !hung && tests > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- dv/sc_tests.txt
# op data blocked status count checksum (op, data, checksum in hex)
# op 0 nop, 1 push, 2 clear, 3 shift, 4-7 illegal; result columns used by shift and illegal
1 1234 0 0 0 0000
1 a5c3 0 0 0 0000
1 0f0f 0 0 0 0000
3 0000 0 0 3 b8f8
3 0000 0 1 0 0000
1 1111 0 0 0 0000
1 2222 0 0 0 0000
2 0000 0 0 0 0000
1 3c3c 0 0 0 0000
3 0000 0 0 1 3c3c
5 beef 0 2 0 0000
0 0000 0 0 0 0000
1 00ff 0 0 0 0000
3 0000 0 0 1 00ff
7 0000 0 2 0 0000
1 0001 0 0 0 0000
1 0002 0 0 0 0000
1 0004 0 0 0 0000
1 0008 0 0 0 0000
1 0010 0 0 0 0000
1 0020 0 0 0 0000
1 0040 0 0 0 0000
1 0080 0 0 0 0000
1 0100 1 0 0 0000
3 0000 0 0 8 00ff

//--- files.f
rtl/scPkg.sv
rtl/scCmdDecode.sv
rtl/scWordFifo.sv
rtl/bitShiftOut.sv
rtl/scResult.sv
rtl/slowControlTop.sv
dv/slowControlTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the slow-control testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

if ! verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module slowControlTb -o simv; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > sim.log 2>&1
simStatus=$?
cat sim.log
if [ "$simStatus" -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "^TEST OK$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1
